/* Makefile */
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := stream_buffer_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* src/credit_drain.sv */
`timescale 1ns/10ps
`default_nettype none

module credit_drain import stream_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    fifo_if.reader fifo,
    output logic   out_valid,
    output data_t  out_data,
    input  logic   out_ready,
    output logic   credit_return
);

    drain_state_e state;
    drain_state_e state_next;
    logic         out_xfer;

    assign out_valid     = (state == DRAIN_HOLD);
    assign out_xfer      = out_valid && out_ready;
    // each delivered word frees one fifo slot upstream
    assign credit_return = out_xfer;

    always_comb begin
        state_next = state;
        fifo.rd_en = 1'b0;
        case (state)
            DRAIN_IDLE: begin
                if (!fifo.empty) begin
                    fifo.rd_en = 1'b1;
                    state_next = DRAIN_FETCH;
                end
            end
            DRAIN_FETCH: begin
                state_next = DRAIN_HOLD;
            end
            DRAIN_HOLD: begin
                // output register is being emptied, so a read may overlap
                if (out_xfer) begin
                    if (!fifo.empty) begin
                        fifo.rd_en = 1'b1;
                        state_next = DRAIN_FETCH;
                    end else begin
                        state_next = DRAIN_IDLE;
                    end
                end
            end
            default: begin
                state_next = DRAIN_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DRAIN_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // rd_data is valid during fetch
    always_ff @(posedge clk) begin
        if (state == DRAIN_FETCH) begin
            out_data <= fifo.rd_data;
        end
    end

endmodule

`default_nettype wire

/* src/credit_sender.sv */
`timescale 1ns/10ps
`default_nettype none

`include "stream_params.svh"

module credit_sender import stream_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  data_t  in_data,
    output logic   in_ready,
    input  logic   credit_return,
    fifo_if.writer fifo
);

    localparam count_t POOL = count_t'(`STREAM_FIFO_DEPTH);

    count_t credits;
    logic   accept;

    // a credit is a guaranteed free fifo slot
    assign in_ready = (credits != '0);
    assign accept   = in_valid && in_ready;

    // accepted words go straight into the fifo
    assign fifo.wr_en   = accept;
    assign fifo.wr_data = in_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= POOL;
        end else begin
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/fifo_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface fifo_if import stream_pkg::*; ();

    // write side
    logic  wr_en;
    data_t wr_data;
    logic  full;
    logic  overflow;

    // read side
    logic  rd_en;
    data_t rd_data;
    logic  empty;
    logic  underflow;

    modport writer (output wr_en, output wr_data, input full, input overflow);

    modport reader (output rd_en, input rd_data, input empty, input underflow);

    modport storage (
        input  wr_en, input  wr_data, input  rd_en,
        output full, output empty, output rd_data,
        output overflow, output underflow
    );

endinterface

`default_nettype wire

/* src/stream_buffer_top.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_buffer_top import stream_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  data_t in_data,
    output logic  in_ready,
    output logic  out_valid,
    output data_t out_data,
    input  logic  out_ready,
    output logic  fifo_error
);

    logic credit_return;

    fifo_if fifo_bus ();

    credit_sender u_sender (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_ready      (in_ready),
        .credit_return (credit_return),
        .fifo          (fifo_bus.writer)
    );

    sync_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .fifo  (fifo_bus.storage)
    );

    credit_drain u_drain (
        .clk           (clk),
        .rst_n         (rst_n),
        .fifo          (fifo_bus.reader),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_ready     (out_ready),
        .credit_return (credit_return)
    );

    // sticky until reset and expected to stay low while credits hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fifo_error <= 1'b0;
        end else if (fifo_bus.overflow || fifo_bus.underflow) begin
            fifo_error <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/stream_params.svh */
`ifndef STREAM_PARAMS_SVH
`define STREAM_PARAMS_SVH

// bits per stream word
`define STREAM_DATA_WIDTH 8

// fifo entries and the size of the credit pool
`define STREAM_FIFO_DEPTH 8

// one bit wider than the fifo address so a count can reach full depth
`define STREAM_CNT_WIDTH 4

`endif

/* src/stream_pkg.sv */
`default_nettype none

`include "stream_params.svh"

package stream_pkg;

    typedef logic [`STREAM_DATA_WIDTH-1:0] data_t;

    typedef logic [`STREAM_CNT_WIDTH-1:0] count_t;

    typedef enum logic [1:0] {
        DRAIN_IDLE,
        DRAIN_FETCH,
        DRAIN_HOLD
    } drain_state_e;

endpackage

`default_nettype wire

/* src/sync_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "stream_params.svh"

module sync_fifo import stream_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    fifo_if.storage fifo
);

    localparam int     ADDR_W   = $clog2(`STREAM_FIFO_DEPTH);
    localparam count_t DEPTH_CNT = count_t'(`STREAM_FIFO_DEPTH);

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    count_t            count;
    data_t             mem [`STREAM_FIFO_DEPTH];
    logic              wr_ok;
    logic              rd_ok;

    // wrap only when stepping past the last entry
    function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] ptr);
        if (ptr == ADDR_W'(`STREAM_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign fifo.full  = (count == DEPTH_CNT);
    assign fifo.empty = (count == '0);

    assign wr_ok = fifo.wr_en && !fifo.full;
    assign rd_ok = fifo.rd_en && !fifo.empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
        end
    end

    // occupancy stays unchanged on a simultaneous read and write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= fifo.wr_data;
        end
        if (rd_ok) begin
            fifo.rd_data <= mem[rd_ptr];
        end
    end

    // refused requests show up one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fifo.overflow  <= 1'b0;
            fifo.underflow <= 1'b0;
        end else begin
            fifo.overflow  <= fifo.wr_en && fifo.full;
            fifo.underflow <= fifo.rd_en && fifo.empty;
        end
    end

endmodule

`default_nettype wire

/* testbench/stream_buffer_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_buffer_assert import stream_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  wr_en,
    input logic  full,
    input logic  rd_en,
    input logic  empty,
    input logic  out_valid,
    input logic  out_ready,
    input data_t out_data
);

    int failures = 0;

    wr_not_full: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full)
        else begin
            $error("write request while the fifo is full");
            failures++;
        end

    rd_not_empty: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !empty)
        else begin
            $error("read request while the fifo is empty");
            failures++;
        end

    // a stalled word stays put until it is taken
    out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else begin
            $error("output word changed while stalled");
            failures++;
        end

endmodule

`default_nettype wire

/* testbench/stream_buffer_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "stream_params.svh"

module stream_buffer_checker import stream_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  data_t in_data,
    input  logic  in_ready,
    input  logic  out_valid,
    input  data_t out_data,
    input  logic  out_ready,
    input  logic  fifo_error,
    output int    accepted,
    output int    delivered,
    output int    data_errors,
    output int    rule_errors
);

    localparam int DEPTH = `STREAM_FIFO_DEPTH;

    data_t ref_q[$];
    data_t expected;
    data_t held_data;
    logic  held;
    logic  first_cycle;
    logic  error_seen;
    int    outstanding;

    always @(posedge clk) begin
        if (!rst_n) begin
            ref_q.delete();
            accepted    = 0;
            delivered   = 0;
            data_errors = 0;
            rule_errors = 0;
            held        = 1'b0;
            held_data   = '0;
            first_cycle = 1'b1;
            error_seen  = 1'b0;
        end else begin
            outstanding = accepted - delivered;
            if (first_cycle && (out_valid || fifo_error || !in_ready)) begin
                $display("FAILED at %0t: after reset out_valid %b fifo_error %b in_ready %b",
                         $time, out_valid, fifo_error, in_ready);
                rule_errors++;
            end
            first_cycle = 1'b0;
            // no credit left exactly when the pool is used up
            if (in_ready != (outstanding != DEPTH)) begin
                $display("FAILED at %0t: in_ready %b with %0d words outstanding",
                         $time, in_ready, outstanding);
                rule_errors++;
            end
            if (fifo_error && !error_seen) begin
                $display("FAILED at %0t: fifo_error is set", $time);
                rule_errors++;
                error_seen = 1'b1;
            end
            if (held && !(out_valid && out_data == held_data)) begin
                $display("FAILED at %0t: stalled output changed, valid %b data %h expected %h",
                         $time, out_valid, out_data, held_data);
                rule_errors++;
            end
            if (out_valid && out_ready) begin
                if (ref_q.size() == 0) begin
                    $display("FAILED at %0t: output word %h with nothing outstanding",
                             $time, out_data);
                    data_errors++;
                end else begin
                    expected = ref_q.pop_front();
                    if (out_data !== expected) begin
                        $display("FAILED at %0t: out_data %h, expected %h",
                                 $time, out_data, expected);
                        data_errors++;
                    end
                end
                delivered++;
            end
            if (in_valid && in_ready) begin
                ref_q.push_back(in_data);
                accepted++;
            end
            held      = out_valid && !out_ready;
            held_data = out_data;
        end
    end

endmodule

`default_nettype wire

/* testbench/stream_buffer_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "stream_params.svh"

module stream_buffer_tb import stream_pkg::*;;

    localparam int          NUM_WORDS      = 300;
    localparam int          TIMEOUT_CYCLES = 10000;
    localparam logic [31:0] SEED           = 32'h2b476f5a;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    data_t       in_data;
    logic        in_ready;
    logic        out_valid;
    data_t       out_data;
    logic        out_ready;
    logic        fifo_error;

    int          accepted;
    int          delivered;
    int          data_errors;
    int          rule_errors;
    int          assert_fails;
    int          timeouts;
    int          sent;
    int          wait_cycles;
    logic        offer_taken;
    logic [31:0] lfsr;
    logic [31:0] bits;

    stream_buffer_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_ready  (out_ready),
        .fifo_error (fifo_error)
    );

    stream_buffer_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_ready   (out_ready),
        .fifo_error  (fifo_error),
        .accepted    (accepted),
        .delivered   (delivered),
        .data_errors (data_errors),
        .rule_errors (rule_errors)
    );

    // read data must hold between reads
    bind sync_fifo stream_buffer_assert fifo_checks (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (fifo.wr_en),
        .full      (fifo.full),
        .rd_en     (fifo.rd_en),
        .empty     (fifo.empty),
        .out_valid (1'b1),
        .out_ready (fifo.rd_en),
        .out_data  (fifo.rd_data)
    );

    bind credit_drain stream_buffer_assert drain_checks (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (1'b0),
        .full      (1'b0),
        .rd_en     (1'b0),
        .empty     (1'b0),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #50 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // once raised, in_valid stays up until the word is taken
    task automatic drive_producer();
        logic [31:0] r;
        if (!in_valid || offer_taken) begin
            in_valid = 1'b0;
            if (sent < NUM_WORDS) begin
                take_bits(2, r);
                if (r[1:0] != 2'b00) begin
                    take_bits(`STREAM_DATA_WIDTH, r);
                    in_data  = data_t'(r);
                    in_valid = 1'b1;
                    sent++;
                end
            end
        end
        offer_taken = in_valid && in_ready;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout at %0t: gave up waiting for %s", $time, what);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        out_ready   = 1'b0;
        lfsr        = SEED;
        timeouts    = 0;
        sent        = 0;
        offer_taken = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // random traffic with stalls on both sides
        wait_cycles = 0;
        while (delivered < NUM_WORDS && wait_cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            wait_cycles++;
            drive_producer();
            take_bits(1, bits);
            out_ready = bits[0];
        end
        if (delivered < NUM_WORDS) begin
            report_timeout("the random traffic to drain");
        end
        in_valid  = 1'b0;
        out_ready = 1'b0;

        // fill up against a blocked output
        take_bits(`STREAM_DATA_WIDTH, bits);
        in_data     = data_t'(bits);
        in_valid    = 1'b1;
        wait_cycles = 0;
        while (in_ready && wait_cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            wait_cycles++;
            take_bits(`STREAM_DATA_WIDTH, bits);
            in_data = data_t'(bits);
        end
        if (in_ready) begin
            report_timeout("in_ready to fall under back-pressure");
        end
        // the last offer stays pending until a credit comes back
        offer_taken = 1'b0;
        repeat (4) @(negedge clk);

        out_ready   = 1'b1;
        wait_cycles = 0;
        while ((delivered < accepted || in_valid) && wait_cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            wait_cycles++;
            drive_producer();
        end
        if (delivered < accepted || in_valid) begin
            report_timeout("the stalled words to drain");
        end

        assert_fails = dut.u_fifo.fifo_checks.failures + dut.u_drain.drain_checks.failures;
        $display("summary: %0d words, %0d data, %0d rule, %0d assertion errors, %0d timeouts",
                 delivered, data_errors, rule_errors, assert_fails, timeouts);
        if (data_errors + rule_errors + assert_fails + timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/stream_pkg.sv
src/fifo_if.sv
src/sync_fifo.sv
src/credit_sender.sv
src/credit_drain.sv
src/stream_buffer_top.sv
testbench/stream_buffer_assert.sv
testbench/stream_buffer_checker.sv
testbench/stream_buffer_tb.sv
